//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it into sim.log and scan the log

verilator --binary --timing --assert -f src.f --top-module tb_useq -o sim_useq \
	> build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_useq > sim.log 2>&1 || echo "Simulator exited with an error status"

grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "FAIL: run ended early"; exit 1; }
echo "PASS"

//--- src.f
+incdir+.
useq_pkg.sv
useq_ctrl.sv
step_counter.sv
word_builder.sv
useq_top.sv
useq_checker.sv
tb_useq.sv

//--- step_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "useq_defs.svh"

module step_counter (
	input  logic                    rst,
	input  logic                    clk,
	input  logic                    run,
	output logic [`USEQ_STEP_W-1:0] step,
	output logic                    last
);

	// Wraps to 0 on the edge that leaves the last word, so the next
	// sequence always starts from step 0
	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
			step <= '0;
		else if (run && !last)
			step <= step + 1'b1;
		else
			step <= '0;
	end

	assign last = (step == `USEQ_STEP_W'(`USEQ_LAST_STEP));

	a_step_range: assert property (@(posedge rst) disable iff (!clk)
		step <= `USEQ_STEP_W'(`USEQ_LAST_STEP));

endmodule

`default_nettype wire

//--- tb_useq.sv
`timescale 1ns/1ps
`default_nettype none

module tb_useq
	import useq_pkg::*;
();

	localparam int CYCLE_LIMIT = 1200;

	logic        rst = 1'b0; // Clock
	logic        clk;        // Asynchronous reset, active low
	cmd_t        cmd;
	ctl_word_t   word;
	int unsigned mismatches;
	int          other_errors = 0;
	int          cycles = 0;
	integer      seed = 98081;
	integer      r;

	always #50 rst = ~rst;

	useq_top dut0 (
		.rst  (rst),
		.clk  (clk),
		.cmd  (cmd),
		.word (word)
	);

	useq_checker chk0 (
		.rst    (rst),
		.clk    (clk),
		.cmd    (cmd),
		.word   (word),
		.errors (mismatches)
	);

	function automatic cmd_t make_cmd(input logic start, input logic ra, input logic rb,
		input logic ext, input logic tba);
		cmd_t c;
		c.start     = start;
		c.route_a   = ra;
		c.route_b   = rb;
		c.ext       = ext;
		c.to_bank_a = tba;
		return c;
	endfunction

	// Start one dispatch, then wait for the word to fall back to zero
	task automatic run_route(input logic ra, input logic rb, input logic ext,
		input logic tba, input string name);
		@(negedge rst);
		cmd = make_cmd(1'b1, ra, rb, ext, tba);
		@(negedge rst);
		cmd.start = 1'b0; // Route levels stay for the ack questions
		if (word == '0)
		begin
			other_errors++;
			$display("ERROR at %0t: %s did not leave idle after start", $time, name);
		end
		while (word != '0)
			@(negedge rst);
		repeat (2) @(negedge rst);
	endtask

	// ************************************************************
	// Stimulus
	// ************************************************************

	initial
	begin
		cmd = '0;
		clk = 1'b0;
		repeat (8) @(negedge rst);
		clk = 1'b1;

		// Route levels move while start stays low
		repeat (10)
		begin
			@(negedge rst);
			r   = $random(seed);
			cmd = make_cmd(1'b0, r[0], r[1], r[2], r[3]);
		end

		run_route(1'b0, 1'b0, 1'b0, 1'b0, "route C");
		run_route(1'b0, 1'b1, 1'b0, 1'b0, "route B");
		run_route(1'b1, 1'b0, 1'b0, 1'b1, "route A to SEQ_A0");
		run_route(1'b1, 1'b0, 1'b0, 1'b0, "route A to SEQ_B0");
		run_route(1'b1, 1'b0, 1'b1, 1'b1, "route A to SEQ_A1");
		run_route(1'b1, 1'b0, 1'b1, 1'b0, "route A to SEQ_B1");

		repeat (400)
		begin
			@(negedge rst);
			r   = $random(seed);
			cmd = make_cmd(r[6:5] == 2'b00, r[0], r[1], r[2], r[3]);
		end

		@(negedge rst);
		cmd = '0;
		while (word != '0)
			@(negedge rst);
		repeat (3) @(negedge rst);

		$display("Closing: %0d mismatches, %0d other errors", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	always @(posedge rst)
	begin
		cycles = cycles + 1;
		if (cycles == CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- useq_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "useq_defs.svh"

module useq_checker
	import useq_pkg::*;
(
	input  logic        rst,
	input  logic        clk,
	input  cmd_t        cmd,
	input  ctl_word_t   word,
	output int unsigned errors
);

	localparam int PH_IDLE = 0, PH_ACK_A = 1, PH_ACK_X = 2, PH_ACK_B = 3;
	localparam int PH_RUN = 4, PH_TRAIL = 5;
	localparam int S_A0 = 0, S_A1 = 1, S_B0 = 2, S_B1 = 3, S_C = 4;
	localparam int TR_NONE = 0, TR_RELEASE = 1, TR_REPORT = 2, TR_STROBE = 3;

	int          m_phase;
	int          m_seq;
	int          m_trail;
	int          m_step;
	int unsigned mismatches = 0;
	ctl_word_t   exp_word;

	assign errors = mismatches;

	// ************************************************************
	// Reference model
	// ************************************************************

	// Reference line numbers in the order the select words use them
	function automatic int ref_line(input int sq, input int slot);
		int lines [5][4];
		lines = '{'{46, 48, 47, 44}, '{61, 63, 62, 60}, '{65, 66, 68, 67},
			'{70, 72, 71, 69}, '{59, 58, 57, 56}};
		return lines[sq][slot];
	endfunction

	function automatic int line_code(input int line);
		if (line == 44)
			return 0;
		else if (line >= 46 && line <= 48)
			return line - 45; // Bank A has no line 45
		else if (line >= 60 && line <= 63)
			return line - 56;
		else if (line >= 65 && line <= 72)
			return line - 65;
		else
			return line - 56; // Bank C
	endfunction

	function automatic ctl_word_t expected_word(input int phase, input int sq,
		input int tr, input int step);
		ctl_word_t w;
		w = '0;
		if (phase == PH_ACK_A)
			w.ack_a = 1'b1;
		else if (phase == PH_ACK_X)
			w.ack_x = 1'b1;
		else if (phase == PH_ACK_B)
			w.load_pair = 2'b11;
		else if (phase == PH_RUN && step % 2 == 0)
		begin
			if (sq == S_C)
				w.bank = BANK_C;
			else if (sq == S_B0 || sq == S_B1)
				w.bank = BANK_B;
			else
				w.bank = BANK_A;
			w.line = `USEQ_LINE_W'(line_code(ref_line(sq, step / 2)));
		end
		else if (phase == PH_RUN)
		begin
			if (sq == S_C)
				w.strobe_c = 1'b1;
			else
				w.strobe_ab = 1'b1;
		end
		else if (phase == PH_TRAIL)
		begin
			if (tr == TR_RELEASE)
				w.rel = 1'b1;
			else if (tr == TR_REPORT)
				w.report = 3'b111;
			else if (tr == TR_STROBE)
				w.strobe_c = 1'b1;
		end
		return w;
	endfunction

	// ************************************************************
	// Compare, then advance the model
	// ************************************************************

	always @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			m_phase = PH_IDLE;
			m_seq   = S_A0;
			m_trail = TR_NONE;
			m_step  = 0;
		end
		else
		begin
			exp_word = expected_word(m_phase, m_seq, m_trail, m_step);
			if (word !== exp_word)
			begin
				mismatches++;
				$display("MISMATCH time=%0t signal=word expected=%h actual=%h",
					$time, exp_word, word);
			end
			case (m_phase)
				PH_IDLE:
					if (cmd.start)
					begin
						m_step = 0;
						if (cmd.route_a)
							m_phase = PH_ACK_A;
						else if (cmd.route_b)
						begin
							m_phase = PH_ACK_B;
							m_seq   = S_A1;
							m_trail = TR_REPORT;
						end
						else
						begin
							m_phase = PH_RUN;
							m_seq   = S_C;
							m_trail = TR_STROBE;
						end
					end
				PH_ACK_A:
					if (cmd.ext)
						m_phase = PH_ACK_X;
					else
					begin
						m_phase = PH_RUN;
						m_seq   = cmd.to_bank_a ? S_A0 : S_B0;
						m_trail = TR_RELEASE;
					end
				PH_ACK_X:
				begin
					m_phase = PH_RUN;
					m_seq   = cmd.to_bank_a ? S_A1 : S_B1;
					m_trail = TR_NONE;
				end
				PH_ACK_B:
					m_phase = PH_RUN;
				PH_RUN:
					if (m_step == `USEQ_LAST_STEP)
					begin
						m_step  = 0;
						m_phase = (m_trail == TR_NONE) ? PH_IDLE : PH_TRAIL;
					end
					else
						m_step = m_step + 1;
				default:
					m_phase = PH_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- useq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module useq_ctrl
	import useq_pkg::*;
(
	input  logic       rst,
	input  logic       clk,
	input  cmd_t       cmd,
	input  logic       last,
	output ctl_state_t state,
	output seq_t       seq,
	output trail_t     trail,
	output logic       run
);

	ctl_state_t state_nx;
	seq_t       seq_nx;
	trail_t     trail_nx;

	// ************************************************************
	// Dispatch
	// ************************************************************

	always_comb
	begin
		state_nx = state;
		seq_nx   = seq;
		trail_nx = trail;
		case (state)
			IDLE:
				if (cmd.start)
				begin
					if (cmd.route_a)
						state_nx = ACK_A;
					else if (cmd.route_b)
					begin
						state_nx = ACK_B;
						seq_nx   = SEQ_A1;
						trail_nx = TRAIL_REPORT;
					end
					else
					begin
						state_nx = RUN; // Route C has no ack word
						seq_nx   = SEQ_C;
						trail_nx = TRAIL_STROBE;
					end
				end
			ACK_A:
				if (cmd.ext)
					state_nx = ACK_X;
				else
				begin
					state_nx = RUN;
					seq_nx   = cmd.to_bank_a ? SEQ_A0 : SEQ_B0;
					trail_nx = TRAIL_RELEASE;
				end
			ACK_X:
			begin
				// The extended branch ends without a trailer
				state_nx = RUN;
				seq_nx   = cmd.to_bank_a ? SEQ_A1 : SEQ_B1;
				trail_nx = TRAIL_NONE;
			end
			ACK_B:
				state_nx = RUN;
			RUN:
				if (last)
					state_nx = (trail == TRAIL_NONE) ? IDLE : TRAIL;
			TRAIL:
				state_nx = IDLE;
			default:
				state_nx = IDLE;
		endcase
	end

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			state <= IDLE;
			seq   <= SEQ_A0;
			trail <= TRAIL_NONE;
		end
		else
		begin
			state <= state_nx;
			seq   <= seq_nx;
			trail <= trail_nx;
		end
	end

	assign run = (state == RUN);

	// ************************************************************
	// Checks
	// ************************************************************

	a_state_legal: assert property (@(posedge rst) disable iff (!clk)
		state inside {IDLE, ACK_A, ACK_X, ACK_B, RUN, TRAIL});

	// Only route C may close with a final strobe
	a_strobe_trail: assert property (@(posedge rst) disable iff (!clk)
		(state != RUN) ##1 (state == RUN) |-> (trail != TRAIL_STROBE || seq == SEQ_C));

endmodule

`default_nettype wire

//--- useq_defs.svh
`ifndef USEQ_DEFS_SVH
`define USEQ_DEFS_SVH

// ************************************************************
// Sequence geometry
// ************************************************************

// Seven words per sequence, counted 0 to 6
`define USEQ_STEP_W    3
`define USEQ_LAST_STEP 6

// Line code within one bank
`define USEQ_LINE_W    3

`endif

//--- useq_pkg.sv
`default_nettype none

`include "useq_defs.svh"

package useq_pkg;

	typedef enum logic [2:0] {
		IDLE,
		ACK_A,
		ACK_X,
		ACK_B,
		RUN,
		TRAIL
	} ctl_state_t;

	typedef enum logic [2:0] {
		SEQ_A0,
		SEQ_A1,
		SEQ_B0,
		SEQ_B1,
		SEQ_C
	} seq_t;

	// Word emitted after the seven-word body
	typedef enum logic [1:0] {
		TRAIL_NONE,
		TRAIL_RELEASE,
		TRAIL_REPORT,
		TRAIL_STROBE
	} trail_t;

	typedef enum logic [1:0] {
		BANK_NONE,
		BANK_A,
		BANK_B,
		BANK_C
	} bank_t;

	typedef struct packed {
		logic start;     // Ref x7
		logic route_a;   // Ref x6
		logic route_b;   // Ref x5
		logic ext;       // Ref x17
		logic to_bank_a; // Ref x16
	} cmd_t;

	typedef struct packed {
		logic                    ack_a;     // Ref y38
		logic                    ack_x;     // Ref y37
		logic [1:0]              load_pair; // Ref y34 and y35
		logic                    rel;       // Release, ref y36
		logic [2:0]              report;    // Ref y15, y32 and y33
		bank_t                   bank;      // Ref y43, y64 and y50
		logic                    strobe_ab; // Ref y45
		logic                    strobe_c;  // Ref y22
		logic [`USEQ_LINE_W-1:0] line;
	} ctl_word_t;

endpackage

`default_nettype wire

//--- useq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "useq_defs.svh"

module useq_top
	import useq_pkg::*;
(
	input  logic      rst,
	input  logic      clk,
	input  cmd_t      cmd,
	output ctl_word_t word
);

	ctl_state_t              state;
	seq_t                    seq;
	trail_t                  trail;
	logic                    run;
	logic [`USEQ_STEP_W-1:0] step;
	logic                    last;

	useq_ctrl ctrl0 (
		.rst   (rst),
		.clk   (clk),
		.cmd   (cmd),
		.last  (last),
		.state (state),
		.seq   (seq),
		.trail (trail),
		.run   (run)
	);

	step_counter cnt0 (
		.rst  (rst),
		.clk  (clk),
		.run  (run),
		.step (step),
		.last (last)
	);

	word_builder wb0 (
		.state (state),
		.seq   (seq),
		.trail (trail),
		.step  (step),
		.word  (word)
	);

endmodule

`default_nettype wire

//--- word_builder.sv
`timescale 1ns/1ps
`default_nettype none

`include "useq_defs.svh"

module word_builder
	import useq_pkg::*;
(
	input  ctl_state_t              state,
	input  seq_t                    seq,
	input  trail_t                  trail,
	input  logic [`USEQ_STEP_W-1:0] step,
	output ctl_word_t               word
);

	logic [`USEQ_STEP_W-2:0]     slot;
	logic [4*`USEQ_LINE_W-1:0]   row;
	logic [`USEQ_LINE_W-1:0]     line_code;
	bank_t                       seq_bank;

	assign slot = step[`USEQ_STEP_W-1:1]; // Index of the select word

	// ************************************************************
	// Line tables
	// ************************************************************

	// Rows list the last select word first
	// Bank A codes 0-3 are lines 44 46 47 48, codes 4-7 are lines 60-63
	always_comb
	begin
		case (seq)
			SEQ_A0:
			begin
				seq_bank = BANK_A;
				row      = {3'd0, 3'd2, 3'd3, 3'd1}; // Lines 46 48 47 44
			end
			SEQ_A1:
			begin
				seq_bank = BANK_A;
				row      = {3'd4, 3'd6, 3'd7, 3'd5}; // Lines 61 63 62 60
			end
			SEQ_B0:
			begin
				seq_bank = BANK_B;
				row      = {3'd2, 3'd3, 3'd1, 3'd0};
			end
			SEQ_B1:
			begin
				seq_bank = BANK_B;
				row      = {3'd4, 3'd6, 3'd7, 3'd5}; // Lines 70 72 71 69
			end
			default:
			begin
				seq_bank = BANK_C;
				row      = {3'd0, 3'd1, 3'd2, 3'd3}; // Lines 59 58 57 56
			end
		endcase
	end

	assign line_code = row[slot*`USEQ_LINE_W +: `USEQ_LINE_W];

	// ************************************************************
	// Word decode
	// ************************************************************

	always_comb
	begin
		word = '0;
		case (state)
			ACK_A: word.ack_a = 1'b1;
			ACK_X: word.ack_x = 1'b1;
			ACK_B: word.load_pair = '1;
			RUN:
				if (!step[0])
				begin
					word.bank = seq_bank;
					word.line = line_code;
				end
				else if (seq == SEQ_C)
					word.strobe_c = 1'b1;
				else
					word.strobe_ab = 1'b1;
			TRAIL:
				case (trail)
					TRAIL_RELEASE: word.rel = 1'b1;
					TRAIL_REPORT:  word.report = '1;
					TRAIL_STROBE:  word.strobe_c = 1'b1;
					default:       word.rel = 1'b0;
				endcase
			default: word.ack_a = 1'b0;
		endcase
	end

	always_comb
	begin
		a_strobe_excl: assert (!(word.strobe_ab && word.strobe_c))
			else $error("strobe_ab and strobe_c both high");
	end

endmodule

`default_nettype wire
